/* design/sdram_pkg.sv */
//========================================
// Shared widths and codes for the memory arbiter,
// the request interface and the memory controller
//========================================

package sdram_pkg;

    // Game bank ports and memory geometry
    localparam int BANKS   = 4;
    localparam int BANK_AW = 10;
    localparam int DATA_W  = 16;
    localparam int BANK_W  = $clog2(BANKS);
    localparam int MEM_WORDS = BANKS << BANK_AW;

    // Cycles from grant to rdy
    localparam int MEM_LAT = 3;
    localparam int LAT_W   = $clog2(MEM_LAT + 1);

    // Requester code needs one value past the game banks
    localparam int SRC_W = $clog2(BANKS + 1);

    typedef logic [BANK_AW-1:0] addr_t;
    typedef logic [BANK_W-1:0]  bank_t;
    typedef logic [DATA_W-1:0]  data_t;
    // Active-low byte write mask with bit 0 on the low byte
    typedef logic [1:0]         dsn_t;
    typedef logic [SRC_W-1:0]   src_t;
    typedef logic [LAT_W-1:0]   lat_t;

    // Programming port sits right after the last game bank
    localparam src_t SRC_PROG = src_t'(BANKS);

endpackage

/* design/mem_req_if.sv */
//========================================
// One granted memory request, arbiter to controller
// ready is the controller's go-ahead for the next req
//========================================

`timescale 1ns/100ps

interface mem_req_if import sdram_pkg::*; ();

    // Single-cycle request strobe and its payload
    logic  req;
    logic  we;
    bank_t bank;
    addr_t addr;
    data_t din;
    dsn_t  dsn;
    src_t  src;

    // High while the controller is idle
    logic  ready;

    modport arb (
        output req, we, bank, addr, din, dsn, src,
        input  ready
    );

    modport ctrl (
        input  req, we, bank, addr, din, dsn, src,
        output ready
    );

endinterface

/* design/bank_arbiter.sv */
//========================================
// Picks one requester per free memory slot
// Programming port first, then game banks round-robin
//========================================

`timescale 1ns/100ps

module bank_arbiter import sdram_pkg::*; (
    input  logic             clk_rom,
    input  logic             arst_n,
    // Game bank ports
    input  addr_t            ba_addr [BANKS],
    input  data_t            ba_din  [BANKS],
    input  dsn_t             ba_dsn  [BANKS],
    input  logic [BANKS-1:0] ba_rd,
    input  logic [BANKS-1:0] ba_wr,
    output logic [BANKS-1:0] ba_ack,
    // ROM programming port
    input  addr_t            prog_addr,
    input  bank_t            prog_ba,
    input  data_t            prog_data,
    input  dsn_t             prog_mask,
    input  logic             prog_we,
    output logic             prog_ack,
    // Towards the memory controller
    mem_req_if.arb           mem
);

    logic [BANKS-1:0] ba_req;
    logic             any_ba;
    logic             ba_grant;
    bank_t            ptr;
    bank_t            win;

    // A read or a write both count as a pending request
    assign ba_req = ba_rd | ba_wr;

    // First requesting bank at or after the pointer
    always_comb begin
        bank_t idx;
        any_ba = 1'b0;
        win    = ptr;
        for (int i = 0; i < BANKS; i++) begin
            idx = ptr + bank_t'(i);
            if (!any_ba && ba_req[idx]) begin
                any_ba = 1'b1;
                win    = idx;
            end
        end
    end

    // prog_we always beats the game banks
    assign prog_ack = mem.ready && prog_we;
    assign ba_grant = mem.ready && !prog_we && any_ba;
    assign mem.req  = prog_ack || ba_grant;

    always_comb begin
        ba_ack = '0;
        if (ba_grant) begin
            ba_ack[win] = 1'b1;
        end
    end

    // Winner's fields onto the request bus
    always_comb begin
        if (prog_we) begin
            mem.we   = 1'b1;
            mem.bank = prog_ba;
            mem.addr = prog_addr;
            mem.din  = prog_data;
            mem.dsn  = prog_mask;
            mem.src  = SRC_PROG;
        end else begin
            // Write wins when rd and wr are both up
            mem.we   = ba_wr[win];
            mem.bank = win;
            mem.addr = ba_addr[win];
            mem.din  = ba_din[win];
            mem.dsn  = ba_dsn[win];
            mem.src  = src_t'(win);
        end
    end

    // Pointer moves past the bank that was just served
    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (ba_grant) begin
            ptr <= win + bank_t'(1);
        end
    end

endmodule

/* design/mem_ctrl.sv */
//========================================
// On-chip word array standing in for the SDRAM chip
// Fixed latency, one access in flight, rdy routed by source
//========================================

`timescale 1ns/100ps

module mem_ctrl import sdram_pkg::*; (
    input  logic             clk_rom,
    input  logic             arst_n,
    // Request from the arbiter
    mem_req_if.ctrl          mem,
    // Responses
    output logic [BANKS-1:0] ba_rdy,
    output logic             prog_rdy,
    output data_t            sdram_dout
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESPOND
    } state_t;

    state_t state;
    lat_t   cnt;
    logic   last;

    // Captured request
    logic   r_we;
    bank_t  r_bank;
    addr_t  r_addr;
    data_t  r_din;
    dsn_t   r_dsn;
    src_t   r_src;

    data_t  mem_arr [MEM_WORDS];
    logic [BANK_W+BANK_AW-1:0] mem_idx;

    assign mem.ready = (state == ST_IDLE);
    assign mem_idx   = {r_bank, r_addr};

    // cnt holds cycles elapsed since the capture edge
    assign last = (state == ST_WAIT) && (cnt == lat_t'(MEM_LAT - 1));

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (mem.req) begin
                        state <= ST_WAIT;
                        cnt   <= lat_t'(1);
                    end
                end
                ST_WAIT: begin
                    if (last) begin
                        state <= ST_RESPOND;
                    end else begin
                        cnt <= cnt + lat_t'(1);
                    end
                end
                // ready comes back after the rdy cycle
                ST_RESPOND: state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_rom) begin
        if (mem.req && state == ST_IDLE) begin
            r_we   <= mem.we;
            r_bank <= mem.bank;
            r_addr <= mem.addr;
            r_din  <= mem.din;
            r_dsn  <= mem.dsn;
            r_src  <= mem.src;
        end
    end

    // Access happens on the last count edge
    always_ff @(posedge clk_rom) begin
        if (last) begin
            if (r_we) begin
                if (!r_dsn[0]) mem_arr[mem_idx][7:0] <= r_din[7:0];
                if (!r_dsn[1]) mem_arr[mem_idx][DATA_W-1:8] <= r_din[DATA_W-1:8];
            end else begin
                sdram_dout <= mem_arr[mem_idx];
            end
        end
    end

    // One rdy pulse lined up with sdram_dout
    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            ba_rdy   <= '0;
            prog_rdy <= 1'b0;
        end else begin
            ba_rdy   <= '0;
            prog_rdy <= 1'b0;
            if (last) begin
                if (r_src == SRC_PROG) begin
                    prog_rdy <= 1'b1;
                end else begin
                    ba_rdy[bank_t'(r_src)] <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/sdram_frame.sv */
//========================================
// Memory access side of the board wrapper
// Four game bank ports and the ROM loader share one array
//========================================

`timescale 1ns/100ps

module sdram_frame import sdram_pkg::*; (
    input  logic             clk_rom,
    input  logic             arst_n,
    // ROM access from game
    input  addr_t            ba0_addr,
    input  addr_t            ba1_addr,
    input  addr_t            ba2_addr,
    input  addr_t            ba3_addr,
    input  logic [BANKS-1:0] ba_rd,
    input  logic [BANKS-1:0] ba_wr,
    output logic [BANKS-1:0] ba_ack,
    output logic [BANKS-1:0] ba_rdy,
    input  data_t            ba0_din,
    input  data_t            ba1_din,
    input  data_t            ba2_din,
    input  data_t            ba3_din,
    input  dsn_t             ba0_dsn,
    input  dsn_t             ba1_dsn,
    input  dsn_t             ba2_dsn,
    input  dsn_t             ba3_dsn,
    // ROM programming
    input  addr_t            prog_addr,
    input  bank_t            prog_ba,
    input  data_t            prog_data,
    input  dsn_t             prog_mask,
    input  logic             prog_we,
    output logic             prog_ack,
    output logic             prog_rdy,
    // Read data shared by all ports
    output data_t            sdram_dout
);

    addr_t ba_addr [BANKS];
    data_t ba_din  [BANKS];
    dsn_t  ba_dsn  [BANKS];

    mem_req_if u_req ();

    // Game ports packed by bank number
    assign ba_addr[0] = ba0_addr;
    assign ba_addr[1] = ba1_addr;
    assign ba_addr[2] = ba2_addr;
    assign ba_addr[3] = ba3_addr;
    assign ba_din[0]  = ba0_din;
    assign ba_din[1]  = ba1_din;
    assign ba_din[2]  = ba2_din;
    assign ba_din[3]  = ba3_din;
    assign ba_dsn[0]  = ba0_dsn;
    assign ba_dsn[1]  = ba1_dsn;
    assign ba_dsn[2]  = ba2_dsn;
    assign ba_dsn[3]  = ba3_dsn;

    bank_arbiter u_arb (
        .clk_rom    ( clk_rom    ),
        .arst_n     ( arst_n     ),
        .ba_addr    ( ba_addr    ),
        .ba_din     ( ba_din     ),
        .ba_dsn     ( ba_dsn     ),
        .ba_rd      ( ba_rd      ),
        .ba_wr      ( ba_wr      ),
        .ba_ack     ( ba_ack     ),
        .prog_addr  ( prog_addr  ),
        .prog_ba    ( prog_ba    ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .prog_ack   ( prog_ack   ),
        .mem        ( u_req.arb  )
    );

    mem_ctrl u_mem (
        .clk_rom    ( clk_rom    ),
        .arst_n     ( arst_n     ),
        .mem        ( u_req.ctrl ),
        .ba_rdy     ( ba_rdy     ),
        .prog_rdy   ( prog_rdy   ),
        .sdram_dout ( sdram_dout )
    );

endmodule

/* verif/sdram_checker.sv */
//========================================
// Request and response protocol assertions
// Bound into every sdram_frame instance
//========================================

`timescale 1ns/100ps

module sdram_checker import sdram_pkg::*; (
    input logic             clk_rom,
    input logic             arst_n,
    input logic [BANKS-1:0] ba_ack,
    input logic [BANKS-1:0] ba_rdy,
    input logic             prog_ack,
    input logic             prog_rdy
);

    // Only one grant per cycle across all ports
    one_ack: assert property (@(posedge clk_rom) disable iff (!arst_n)
        $onehot0({ba_ack, prog_ack}))
        else $error("more than one ack in the same cycle");

    // rdy pattern repeats the ack pattern MEM_LAT cycles later
    ack_to_rdy: assert property (@(posedge clk_rom) disable iff (!arst_n)
        {ba_rdy, prog_rdy} == $past({ba_ack, prog_ack}, MEM_LAT))
        else $error("rdy does not follow its ack after MEM_LAT cycles");

    // All handshakes quiet in reset
    quiet_in_reset: assert property (@(posedge clk_rom)
        !arst_n |-> ({ba_ack, ba_rdy, prog_ack, prog_rdy} == '0))
        else $error("ack or rdy high while arst_n is low");

endmodule

bind sdram_frame sdram_checker u_chk (
    .clk_rom  ( clk_rom  ),
    .arst_n   ( arst_n   ),
    .ba_ack   ( ba_ack   ),
    .ba_rdy   ( ba_rdy   ),
    .prog_ack ( prog_ack ),
    .prog_rdy ( prog_rdy )
);

/* verif/tb_top.sv */
//========================================
// Testbench for the shared memory frame
// LFSR traffic on all ports checked against a memory model
//========================================

`timescale 1ns/100ps

module tb_top import sdram_pkg::*; ();

    // Each bank uses a window of 2^WIN_W words spread over the address
    localparam int WIN_W   = 5;
    localparam int WIN     = 1 << WIN_W;
    localparam int FILL_N  = BANKS * WIN;
    localparam int LOAD_N  = 64;
    localparam int READ_N  = 100;
    localparam int MASK_N  = 200;
    localparam int RR_N    = 64;
    localparam int MIX_N   = 400;
    localparam int TOTAL_N = FILL_N + LOAD_N + READ_N + MASK_N + BANKS + 1 + RR_N + MIX_N;
    localparam int WDOG_CYC = TOTAL_N * (MEM_LAT + 1) * (BANKS + 1) * 2;

    typedef struct packed {
        int    due;
        src_t  src;
        logic  rd;
        data_t data;
    } exp_t;

    logic             clk_rom;
    logic             arst_n;
    addr_t            ba_addr [BANKS];
    data_t            ba_din  [BANKS];
    dsn_t             ba_dsn  [BANKS];
    logic [BANKS-1:0] ba_rd, ba_wr, ba_ack, ba_rdy;
    addr_t            prog_addr;
    bank_t            prog_ba;
    data_t            prog_data;
    dsn_t             prog_mask;
    logic             prog_we, prog_ack, prog_rdy;
    data_t            sdram_dout;

    // Reference model and traffic state
    data_t            model [BANKS][WIN];
    exp_t             exp_q [$];
    logic [31:0]      lfsr;
    bank_t            rr_ptr;
    logic [BANKS-1:0] ba_busy;
    logic             prog_busy;
    logic             game_en, prog_en, wr_en, rr_check;
    int               game_odds, prog_odds;
    int               cyc, busy_until, acks, fill_next, ack_src, last_bank;
    int               mism_cnt, err_cnt;

    sdram_frame DUT (
        .clk_rom    ( clk_rom    ),
        .arst_n     ( arst_n     ),
        .ba0_addr   ( ba_addr[0] ),
        .ba1_addr   ( ba_addr[1] ),
        .ba2_addr   ( ba_addr[2] ),
        .ba3_addr   ( ba_addr[3] ),
        .ba_rd      ( ba_rd      ),
        .ba_wr      ( ba_wr      ),
        .ba_ack     ( ba_ack     ),
        .ba_rdy     ( ba_rdy     ),
        .ba0_din    ( ba_din[0]  ),
        .ba1_din    ( ba_din[1]  ),
        .ba2_din    ( ba_din[2]  ),
        .ba3_din    ( ba_din[3]  ),
        .ba0_dsn    ( ba_dsn[0]  ),
        .ba1_dsn    ( ba_dsn[1]  ),
        .ba2_dsn    ( ba_dsn[2]  ),
        .ba3_dsn    ( ba_dsn[3]  ),
        .prog_addr  ( prog_addr  ),
        .prog_ba    ( prog_ba    ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .prog_ack   ( prog_ack   ),
        .prog_rdy   ( prog_rdy   ),
        .sdram_dout ( sdram_dout )
    );

    initial begin
        clk_rom = 1'b0;
        forever #4 clk_rom = ~clk_rom;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic addr_t to_addr(input logic [WIN_W-1:0] idx);
        return addr_t'({idx, idx ^ 5'h15});
    endfunction

    function automatic logic [WIN_W-1:0] idx_of(input addr_t a);
        return a[BANK_AW-1 -: WIN_W];
    endfunction

    // Expected {ba_rdy, prog_rdy} for one source
    function automatic logic [BANKS:0] rdy_vec(input src_t s);
        logic [BANKS:0] v;
        v = '0;
        if (s == SRC_PROG) begin
            v[0] = 1'b1;
        end else begin
            v[int'(s) + 1] = 1'b1;
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        mism_cnt++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("Error counts: %0d mismatches, %0d other errors", mism_cnt, err_cnt);
    endtask

    task automatic check_quiet(input string when_s);
        assert (ba_ack == '0 && ba_rdy == '0 && !prog_ack && !prog_rdy)
            else report_mismatch($sformatf("ack or rdy high %s", when_s));
    endtask

    // Only unmasked bytes change
    task automatic write_model(input bank_t bk, input addr_t a, input data_t d, input dsn_t m);
        if (!m[0]) model[bk][idx_of(a)][7:0] = d[7:0];
        if (!m[1]) model[bk][idx_of(a)][15:8] = d[15:8];
    endtask

    task automatic raise_game(input int b);
        logic wr;
        wr = wr_en && (rand_bits(1) != 0);
        ba_busy[b] = 1'b1;
        ba_wr[b]   <= wr;
        ba_rd[b]   <= !wr || (rand_bits(1) != 0);
        ba_addr[b] <= to_addr(WIN_W'(rand_bits(WIN_W)));
        ba_din[b]  <= data_t'(rand_bits(DATA_W));
        ba_dsn[b]  <= dsn_t'(rand_bits(2));
    endtask

    // Whole words in order first, then random words and masks
    task automatic raise_prog();
        prog_busy = 1'b1;
        prog_we   <= 1'b1;
        prog_data <= data_t'(rand_bits(DATA_W));
        if (fill_next < FILL_N) begin
            prog_ba   <= bank_t'(fill_next / WIN);
            prog_addr <= to_addr(WIN_W'(fill_next % WIN));
            prog_mask <= 2'b00;
            fill_next++;
        end else begin
            prog_ba   <= bank_t'(rand_bits(2));
            prog_addr <= to_addr(WIN_W'(rand_bits(WIN_W)));
            prog_mask <= dsn_t'(rand_bits(2));
        end
    endtask

    // Acked ports drop their request, idle ports may raise a new one
    task automatic drive_ports();
        for (int b = 0; b < BANKS; b++) begin
            if (!ba_busy[b]) begin
                ba_rd[b] <= 1'b0;
                ba_wr[b] <= 1'b0;
                if (game_en && rand_bits(2) < game_odds) raise_game(b);
            end
        end
        if (!prog_busy) begin
            prog_we <= 1'b0;
            if (prog_en && rand_bits(3) < prog_odds) raise_prog();
        end
    endtask

    task automatic push_exp(input src_t s, input logic rd, input data_t d);
        exp_t e;
        e.due  = cyc + MEM_LAT;
        e.src  = s;
        e.rd   = rd;
        e.data = d;
        exp_q.push_back(e);
        busy_until = cyc + MEM_LAT + 1;
        acks++;
    endtask

    task automatic observe();
        exp_t             e;
        logic [BANKS-1:0] pend;
        logic [BANKS-1:0] exp_ba;
        logic             ready;
        int               k;
        cyc++;
        ack_src = -1;
        // Response due this cycle
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            assert ({ba_rdy, prog_rdy} == rdy_vec(e.src)) else report_mismatch(
                $sformatf("rdy %b, expected %b", {ba_rdy, prog_rdy}, rdy_vec(e.src)));
            if (e.rd) begin
                assert (sdram_dout == e.data) else report_mismatch(
                    $sformatf("read data %h, expected %h", sdram_dout, e.data));
            end
        end else begin
            assert ({ba_rdy, prog_rdy} == '0)
                else report_error("rdy pulse while no access was due");
        end
        // Grant expected from priority and round-robin rules
        ready  = (cyc >= busy_until);
        pend   = ba_rd | ba_wr;
        exp_ba = '0;
        if (ready && !prog_we) begin
            // Walk back towards the pointer so the nearest request wins
            for (int i = BANKS - 1; i >= 0; i--) begin
                k = (int'(rr_ptr) + i) % BANKS;
                if (pend[k]) begin
                    exp_ba    = '0;
                    exp_ba[k] = 1'b1;
                end
            end
        end
        assert (prog_ack == (ready && prog_we) && ba_ack == exp_ba) else report_mismatch(
            $sformatf("acks prog %b banks %b, expected %b %b",
                      prog_ack, ba_ack, ready && prog_we, exp_ba));
        if (prog_ack) begin
            ack_src   = int'(SRC_PROG);
            prog_busy = 1'b0;
            write_model(prog_ba, prog_addr, prog_data, prog_mask);
            push_exp(SRC_PROG, 1'b0, '0);
        end
        for (int i = 0; i < BANKS; i++) begin
            if (ba_ack[i]) begin
                ack_src    = i;
                ba_busy[i] = 1'b0;
                push_exp(src_t'(i), !ba_wr[i], model[i][idx_of(ba_addr[i])]);
                if (ba_wr[i]) write_model(bank_t'(i), ba_addr[i], ba_din[i], ba_dsn[i]);
                if (rr_check && last_bank >= 0) begin
                    assert (i == (last_bank + 1) % BANKS) else report_mismatch(
                        $sformatf("bank %0d acked after bank %0d", i, last_bank));
                end
                last_bank = i;
                rr_ptr    = bank_t'((i + 1) % BANKS);
            end
        end
    endtask

    task automatic step();
        @(negedge clk_rom);
        observe();
        @(posedge clk_rom);
        drive_ports();
    endtask

    task automatic drain();
        while (prog_busy || ba_busy != '0 || exp_q.size() != 0) step();
    endtask

    task automatic run_phase(input int n);
        int target;
        target = acks + n;
        while (acks < target) step();
        prog_en = 1'b0;
        game_en = 1'b0;
        drain();
    endtask

    initial begin
        lfsr      = 32'hf6c8e578;
        rr_ptr    = '0;
        ba_busy   = '0;
        prog_busy = 1'b0;
        game_en   = 1'b0;
        prog_en   = 1'b0;
        wr_en     = 1'b0;
        rr_check  = 1'b0;
        game_odds = 0;
        prog_odds = 0;
        cyc       = 0;
        busy_until = 0;
        acks      = 0;
        fill_next = 0;
        ack_src   = -1;
        last_bank = -1;
        mism_cnt  = 0;
        err_cnt   = 0;
        arst_n    <= 1'b0;
        ba_rd     <= '0;
        ba_wr     <= '0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_ba   <= '0;
        prog_data <= '0;
        prog_mask <= '0;
        for (int b = 0; b < BANKS; b++) begin
            ba_addr[b] <= '0;
            ba_din[b]  <= '0;
            ba_dsn[b]  <= '0;
        end
        repeat (5) begin
            @(negedge clk_rom);
            check_quiet("during reset");
        end
        @(posedge clk_rom);
        arst_n <= 1'b1;
        @(negedge clk_rom);
        check_quiet("in the first cycle after reset");

        // ROM load into all banks followed by game reads
        prog_en   = 1'b1;
        prog_odds = 8;
        run_phase(FILL_N + LOAD_N);
        game_en   = 1'b1;
        game_odds = 2;
        run_phase(READ_N);

        // Byte-masked writes mixed with reads
        game_en = 1'b1;
        wr_en   = 1'b1;
        run_phase(MASK_N);

        // Loader and all banks raised in the same cycle
        wr_en = 1'b0;
        raise_prog();
        for (int b = 0; b < BANKS; b++) raise_game(b);
        step();
        assert (ack_src == int'(SRC_PROG)) else report_mismatch(
            $sformatf("first grant went to source %0d, not the loader", ack_src));
        drain();

        // All banks asking all the time
        game_en   = 1'b1;
        game_odds = 4;
        rr_check  = 1'b1;
        last_bank = -1;
        run_phase(RR_N);
        rr_check  = 1'b0;

        // Everything at once
        prog_en   = 1'b1;
        prog_odds = 1;
        game_en   = 1'b1;
        game_odds = 1;
        wr_en     = 1'b1;
        run_phase(MIX_N);

        print_counts();
        if (mism_cnt + err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk_rom);
        $display("Timeout after %0d cycles with requests still waiting for ack", WDOG_CYC);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tb.f */
design/sdram_pkg.sv
design/mem_req_if.sv
design/bank_arbiter.sv
design/mem_ctrl.sv
design/sdram_frame.sv
verif/sdram_checker.sv
verif/tb_top.sv

/* Makefile */
# Verilator flow for the memory frame testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
